/* hdl/nabp_defs.svh */
`ifndef NABP_DEFS_SVH
`define NABP_DEFS_SVH

// samples in one projection line
`define kLineSize 64

// signed line index, wide enough to reach past the line on either side
`define kSLength 8

// raw and filtered sample widths
`define kRawLength 12
`define kFilteredLength 16

// filter coefficient width and the scaling applied after the tap sum
`define kCoefLength 8
`define kCoefShift 6

// odd tap count, centred on the middle tap
`define kFilterTaps 5
`define kCentreTap ((`kFilterTaps - 1) / 2)

// cycles spent in delay_s before the first write
// two look-ahead samples, one memory read, one filter output register
`define kFillDelay 4

`endif

/* hdl/nabp_pkg.sv */
`include "nabp_defs.svh"

package nabp_pkg;

    // raw projection sample as loaded by the host
    typedef logic signed [`kRawLength-1:0] raw_sample_t;

    // sample after filtering and scaling
    typedef logic signed [`kFilteredLength-1:0] filt_sample_t;

    // one filter tap
    typedef logic signed [`kCoefLength-1:0] coef_t;

    // position along the line, signed for out-of-range lookups
    typedef logic signed [`kSLength-1:0] s_index_t;

    // fill controller states
    typedef enum logic [1:0]
    {
        ready_s,
        delay_s,
        fill_s
    } fill_state_t;

endpackage

/* hdl/line_dual_port_ram.sv */
`timescale 1ns/1ps

`include "nabp_defs.svh"

module line_dual_port_ram
#(
    parameter type payload_t = nabp_pkg::filt_sample_t,
    parameter int  depth     = `kLineSize
)
(
    input  logic               clk,
    input  logic               we_0,
    input  nabp_pkg::s_index_t addr_0,
    input  payload_t           data_in_0,
    input  nabp_pkg::s_index_t addr_1,
    output payload_t           data_out_0,
    output payload_t           data_out_1
);

    localparam int addr_bits = $clog2(depth);

    payload_t                 mem [depth];
    logic [addr_bits-1:0]     row_0;
    logic [addr_bits-1:0]     row_1;

    // low bits only, out-of-line indices alias
    assign row_0 = addr_0[addr_bits-1:0];
    assign row_1 = addr_1[addr_bits-1:0];

    // port 0 writes and reads, old data on a write cycle
    always_ff @(posedge clk)
    begin
        if (we_0)
            mem[row_0] <= data_in_0;
        data_out_0 <= mem[row_0];
    end

    // port 1 is read only
    always_ff @(posedge clk)
    begin
        data_out_1 <= mem[row_1];
    end

endmodule

/* hdl/filter_coeff_regs.sv */
`timescale 1ns/1ps

`include "nabp_defs.svh"

module filter_coeff_regs
(
    input  logic                                 clk,
    input  logic                                 reset_n,
    input  logic                                 coef_we,
    input  logic [$clog2(`kFilterTaps)-1:0]      coef_idx,
    input  nabp_pkg::coef_t                      coef_data,
    output logic [`kFilterTaps*`kCoefLength-1:0] taps
);

    // unity gain once the tap sum is shifted down
    localparam nabp_pkg::coef_t unity_tap = nabp_pkg::coef_t'(1 << `kCoefShift);

    nabp_pkg::coef_t coef_q [`kFilterTaps];
    logic            idx_in_range;

    // indices past the last tap are dropped
    assign idx_in_range = (coef_idx < `kFilterTaps);

    // identity filter after reset
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            for (int k = 0; k < `kFilterTaps; k++)
            begin
                if (k == `kCentreTap)
                    coef_q[k] <= unity_tap;
                else
                    coef_q[k] <= '0;
            end
        end
        else if (coef_we && idx_in_range)
        begin
            coef_q[coef_idx] <= coef_data;
        end
    end

    // tap k sits at bits [k*width +: width]
    always_comb
    begin
        for (int k = 0; k < `kFilterTaps; k++)
        begin
            taps[k*`kCoefLength +: `kCoefLength] = coef_q[k];
        end
    end

endmodule

/* hdl/projection_filter.sv */
`timescale 1ns/1ps

`include "nabp_defs.svh"

module projection_filter
(
    input  logic                                 clk,
    input  logic                                 reset_n,
    input  nabp_pkg::raw_sample_t                raw_q,
    input  logic                                 sample_valid,
    input  logic [`kFilterTaps*`kCoefLength-1:0] taps,
    output nabp_pkg::filt_sample_t               filt_val
);

    // full precision of the tap sum, no overflow for any coefficient set
    localparam int acc_bits = `kRawLength + `kCoefLength + $clog2(`kFilterTaps);

    nabp_pkg::raw_sample_t      window [`kFilterTaps];
    nabp_pkg::raw_sample_t      gated_sample;
    nabp_pkg::coef_t            tap [`kFilterTaps];
    logic signed [acc_bits-1:0] acc;
    logic signed [acc_bits-1:0] scaled;

    // outside the line the raw data counts as zero
    assign gated_sample = sample_valid ? raw_q : '0;

    // split the flat tap vector
    always_comb
    begin
        for (int k = 0; k < `kFilterTaps; k++)
        begin
            tap[k] = nabp_pkg::coef_t'(taps[k*`kCoefLength +: `kCoefLength]);
        end
    end

    // newest sample enters at the top
    // window[k] holds raw[s + k - centre] for the output being formed
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            for (int k = 0; k < `kFilterTaps; k++)
            begin
                window[k] <= '0;
            end
        end
        else
        begin
            for (int k = 0; k < `kFilterTaps - 1; k++)
            begin
                window[k] <= window[k + 1];
            end
            window[`kFilterTaps - 1] <= gated_sample;
        end
    end

    // multiply-accumulate across the window
    always_comb
    begin
        acc = '0;
        for (int k = 0; k < `kFilterTaps; k++)
        begin
            acc = acc + tap[k] * window[k];
        end
    end

    // arithmetic shift keeps the sign of negative sums
    assign scaled = acc >>> `kCoefShift;

    // output register, top bits are dropped
    always_ff @(posedge clk)
    begin
        filt_val <= scaled[`kFilteredLength-1:0];
    end

endmodule

/* hdl/filtered_ram_fill.sv */
`timescale 1ns/1ps

`include "nabp_defs.svh"

module filtered_ram_fill
(
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   fill_kick,
    input  nabp_pkg::filt_sample_t filt_val,
    input  nabp_pkg::s_index_t     pr0_s,
    input  nabp_pkg::s_index_t     pr1_s,
    output logic                   fill_done,
    output nabp_pkg::s_index_t     read_s,
    output logic                   sample_valid,
    output nabp_pkg::filt_sample_t pr0_val,
    output nabp_pkg::filt_sample_t pr1_val
);

    nabp_pkg::fill_state_t state;
    nabp_pkg::fill_state_t next_state;
    nabp_pkg::s_index_t    read_itr;
    nabp_pkg::s_index_t    write_itr;
    nabp_pkg::s_index_t    port0_s;
    logic                  kick_accepted;
    logic                  read_en;
    logic                  delay_done;
    logic                  last_write;
    logic                  write_enable;

    // kicks outside ready_s are ignored
    assign kick_accepted = (state == nabp_pkg::ready_s) && fill_kick;

    // read runs from the kick cycle until it reaches the end of the line
    assign read_en = kick_accepted ||
                     ((state != nabp_pkg::ready_s) && (read_itr != `kLineSize));

    // read iterator is one ahead of the delay count
    assign delay_done   = (state == nabp_pkg::delay_s) && (read_itr == `kFillDelay);
    assign write_enable = (state == nabp_pkg::fill_s);
    assign last_write   = write_enable && (write_itr == `kLineSize - 1);

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            state <= nabp_pkg::ready_s;
        else
            state <= next_state;
    end

    // mealy next state
    always_comb
    begin
        next_state = state;
        case (state)
            nabp_pkg::ready_s:
                if (fill_kick)
                    next_state = nabp_pkg::delay_s;
            nabp_pkg::delay_s:
                if (delay_done)
                    next_state = nabp_pkg::fill_s;
            nabp_pkg::fill_s:
                if (last_write)
                    next_state = nabp_pkg::ready_s;
            default:
                next_state = nabp_pkg::ready_s;
        endcase
    end

    // read iterator saturates at the line size
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            read_itr <= '0;
        else if (read_en)
            read_itr <= read_itr + 1'b1;
        else if (state == nabp_pkg::ready_s)
            read_itr <= '0;
    end

    // write iterator only moves during fill_s
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            write_itr <= '0;
        else if (write_enable && !last_write)
            write_itr <= write_itr + 1'b1;
        else
            write_itr <= '0;
    end

    // aligned with raw_q, which lags read_s by one cycle
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            sample_valid <= 1'b0;
        else
            sample_valid <= read_en;
    end

    assign read_s    = read_itr;
    assign fill_done = last_write;

    // port 0 belongs to the fill unless idle
    assign port0_s = (state == nabp_pkg::ready_s) ? pr0_s : write_itr;

    line_dual_port_ram
    #(
        .payload_t (nabp_pkg::filt_sample_t)
    )
    filtered_ram
    (
        .clk        (clk),
        .we_0       (write_enable),
        .addr_0     (port0_s),
        .data_in_0  (filt_val),
        .addr_1     (pr1_s),
        .data_out_0 (pr0_val),
        .data_out_1 (pr1_val)
    );

endmodule

/* hdl/filtered_line_top.sv */
`timescale 1ns/1ps

`include "nabp_defs.svh"

module filtered_line_top
(
    input  logic                              clk,
    input  logic                              reset_n,
    // raw line load
    input  logic                              raw_we,
    input  nabp_pkg::s_index_t                raw_addr,
    input  nabp_pkg::raw_sample_t             raw_data,
    // filter taps
    input  logic                              coef_we,
    input  logic [$clog2(`kFilterTaps)-1:0]   coef_idx,
    input  nabp_pkg::coef_t                   coef_data,
    // fill control
    input  logic                              fill_kick,
    output logic                              fill_done,
    // processing ports
    input  nabp_pkg::s_index_t                pr0_s,
    input  nabp_pkg::s_index_t                pr1_s,
    output nabp_pkg::filt_sample_t            pr0_val,
    output nabp_pkg::filt_sample_t            pr1_val
);

    nabp_pkg::s_index_t                 read_s;
    nabp_pkg::raw_sample_t              raw_q;
    logic                               sample_valid;
    logic [`kFilterTaps*`kCoefLength-1:0] taps;
    nabp_pkg::filt_sample_t             filt_val;

    // host writes on port 0, fill reads on port 1
    line_dual_port_ram
    #(
        .payload_t (nabp_pkg::raw_sample_t)
    )
    raw_ram
    (
        .clk        (clk),
        .we_0       (raw_we),
        .addr_0     (raw_addr),
        .data_in_0  (raw_data),
        .addr_1     (read_s),
        .data_out_0 (),
        .data_out_1 (raw_q)
    );

    filter_coeff_regs coeff_regs
    (
        .clk       (clk),
        .reset_n   (reset_n),
        .coef_we   (coef_we),
        .coef_idx  (coef_idx),
        .coef_data (coef_data),
        .taps      (taps)
    );

    projection_filter filter
    (
        .clk          (clk),
        .reset_n      (reset_n),
        .raw_q        (raw_q),
        .sample_valid (sample_valid),
        .taps         (taps),
        .filt_val     (filt_val)
    );

    filtered_ram_fill fill_ctrl
    (
        .clk          (clk),
        .reset_n      (reset_n),
        .fill_kick    (fill_kick),
        .filt_val     (filt_val),
        .pr0_s        (pr0_s),
        .pr1_s        (pr1_s),
        .fill_done    (fill_done),
        .read_s       (read_s),
        .sample_valid (sample_valid),
        .pr0_val      (pr0_val),
        .pr1_val      (pr1_val)
    );

endmodule

/* sim/filtered_line_tb.sv */
`timescale 1ns/1ps

`include "nabp_defs.svh"

module filtered_line_tb;

    localparam int rows        = 5;
    localparam int ramp_kind   = 0;
    localparam int const_kind  = 1;
    localparam int random_kind = 2;
    localparam int fill_cycles = `kFillDelay + `kLineSize;
    // load, tap writes, delay, fill, read back, margin
    localparam int row_cycles  = `kLineSize + `kFilterTaps + 1 + fill_cycles + `kLineSize + 10;
    localparam int cycle_limit = rows * row_cycles + 10;

    typedef struct packed
    {
        logic                                 keep_taps;
        logic                                 rand_taps;
        logic [1:0]                           kind;
        logic [11:0]                          level;
        logic                                 second_kick;
        logic [`kFilterTaps*`kCoefLength-1:0] coefs;
    } stim_row_t;

    logic                            clk;
    logic                            reset_n;
    logic                            raw_we;
    nabp_pkg::s_index_t              raw_addr;
    nabp_pkg::raw_sample_t           raw_data;
    logic                            coef_we;
    logic [$clog2(`kFilterTaps)-1:0] coef_idx;
    nabp_pkg::coef_t                 coef_data;
    logic                            fill_kick;
    logic                            fill_done;
    nabp_pkg::s_index_t              pr0_s;
    nabp_pkg::s_index_t              pr1_s;
    nabp_pkg::filt_sample_t          pr0_val;
    nabp_pkg::filt_sample_t          pr1_val;

    stim_row_t              stim_table [rows];
    nabp_pkg::raw_sample_t  raw_line [`kLineSize];
    nabp_pkg::coef_t        coef_model [`kFilterTaps];
    nabp_pkg::filt_sample_t expected [`kLineSize];
    logic [31:0]            lfsr;
    int                     errors;
    int                     checks;
    int                     cycle_count = 0;
    logic                   waiting_done;

    filtered_line_top dut
    (
        .clk       (clk),
        .reset_n   (reset_n),
        .raw_we    (raw_we),
        .raw_addr  (raw_addr),
        .raw_data  (raw_data),
        .coef_we   (coef_we),
        .coef_idx  (coef_idx),
        .coef_data (coef_data),
        .fill_kick (fill_kick),
        .fill_done (fill_done),
        .pr0_s     (pr0_s),
        .pr1_s     (pr1_s),
        .pr0_val   (pr0_val),
        .pr1_val   (pr1_val)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit)
        begin
            $display("run stopped, no finish after %0d cycles", cycle_count);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // fill_done must stay low outside a kicked fill
    always @(negedge clk)
    begin
        if (reset_n && !waiting_done)
        begin
            checks++;
            assert (fill_done === 1'b0)
            else
            begin
                errors++;
                $display("[FAIL] %0t fill_done outside a fill expected 0 got %b",
                         $time, fill_done);
            end
        end
    end

    // right-shift galois lfsr for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h80200003;
        else
            return s >> 1;
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // centred FIR over the line with zeros outside it
    function automatic nabp_pkg::filt_sample_t model_filter(input int s);
        int acc;
        int idx;
        int shifted;
        acc = 0;
        for (int k = 0; k < `kFilterTaps; k++)
        begin
            idx = s + k - (`kFilterTaps - 1) / 2;
            if (idx >= 0 && idx < `kLineSize)
                acc = acc + int'(coef_model[k]) * int'(raw_line[idx]);
        end
        shifted = acc >>> `kCoefShift;
        return nabp_pkg::filt_sample_t'(shifted);
    endfunction

    task automatic fill_table();
        // concatenations list tap 4 first
        stim_table[0] = '{keep_taps: 1'b1, rand_taps: 1'b0, kind: ramp_kind,
                          level: -12'sd1000, second_kick: 1'b0,
                          coefs: {8'sd0, 8'sd0, 8'sd64, 8'sd0, 8'sd0}};
        stim_table[1] = '{keep_taps: 1'b0, rand_taps: 1'b0, kind: const_kind,
                          level: -12'sd700, second_kick: 1'b1,
                          coefs: {8'sd0, 8'sd0, 8'sd64, 8'sd0, 8'sd0}};
        stim_table[2] = '{keep_taps: 1'b0, rand_taps: 1'b1, kind: random_kind,
                          level: 12'sd0, second_kick: 1'b0, coefs: '0};
        stim_table[3] = '{keep_taps: 1'b0, rand_taps: 1'b1, kind: random_kind,
                          level: 12'sd0, second_kick: 1'b1, coefs: '0};
        stim_table[4] = '{keep_taps: 1'b0, rand_taps: 1'b0, kind: ramp_kind,
                          level: -12'sd1500, second_kick: 1'b0,
                          coefs: {-8'sd3, 8'sd10, 8'sd40, 8'sd10, -8'sd3}};
    endtask

    task automatic build_row(input stim_row_t row);
        logic [31:0] v;
        for (int k = 0; k < `kFilterTaps; k++)
            coef_model[k] = row.coefs[k*`kCoefLength +: `kCoefLength];
        if (row.rand_taps)
        begin
            // mirrored around the centre tap
            for (int k = 0; k <= (`kFilterTaps - 1) / 2; k++)
            begin
                take_bits(`kCoefLength, v);
                coef_model[k] = v[`kCoefLength-1:0];
                coef_model[`kFilterTaps - 1 - k] = v[`kCoefLength-1:0];
            end
        end
        for (int s = 0; s < `kLineSize; s++)
        begin
            if (row.kind == random_kind)
            begin
                take_bits(`kRawLength, v);
                raw_line[s] = v[`kRawLength-1:0];
            end
            else if (row.kind == const_kind)
                raw_line[s] = row.level;
            else
                raw_line[s] = nabp_pkg::raw_sample_t'(int'($signed(row.level)) + 37 * s);
        end
        for (int s = 0; s < `kLineSize; s++)
            expected[s] = model_filter(s);
    endtask

    task automatic load_line();
        for (int s = 0; s < `kLineSize; s++)
        begin
            @(posedge clk);
            raw_we   <= 1'b1;
            raw_addr <= nabp_pkg::s_index_t'(s);
            raw_data <= raw_line[s];
        end
    endtask

    task automatic write_taps();
        for (int k = 0; k < `kFilterTaps; k++)
        begin
            @(posedge clk);
            raw_we    <= 1'b0;
            coef_we   <= 1'b1;
            coef_idx  <= k;
            coef_data <= coef_model[k];
        end
        // out-of-range tap index that the bank drops
        @(posedge clk);
        coef_idx  <= `kFilterTaps;
        coef_data <= 8'sd127;
    endtask

    task automatic run_fill(input logic second_kick);
        int   cycles;
        logic found;
        @(posedge clk);
        raw_we       <= 1'b0;
        coef_we      <= 1'b0;
        fill_kick    <= 1'b1;
        waiting_done = 1'b1;
        // this edge samples the kick
        @(posedge clk);
        fill_kick <= 1'b0;
        cycles = 0;
        found  = 1'b0;
        while (!found && cycles < 2 * fill_cycles)
        begin
            @(negedge clk);
            cycles++;
            if (fill_done === 1'b1)
                found = 1'b1;
            else
            begin
                @(posedge clk);
                fill_kick <= second_kick && (cycles == 20);
            end
        end
        checks++;
        assert (found)
        else
        begin
            errors++;
            $display("fill_done never arrived within %0d cycles of the kick", 2 * fill_cycles);
        end
        if (found)
        begin
            checks++;
            assert (cycles == fill_cycles)
            else
            begin
                errors++;
                $display("[FAIL] %0t fill_done latency expected %0d got %0d",
                         $time, fill_cycles, cycles);
            end
            @(posedge clk);
            fill_kick <= 1'b0;
            @(negedge clk);
            checks++;
            assert (fill_done === 1'b0)
            else
            begin
                errors++;
                $display("[FAIL] %0t fill_done after its pulse expected 0 got %b",
                         $time, fill_done);
            end
        end
    endtask

    task automatic check_value(input string name, input int index,
                               input nabp_pkg::filt_sample_t got,
                               input nabp_pkg::filt_sample_t exp);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("[FAIL] %0t %s for s=%0d expected %0d got %0d",
                     $time, name, index, exp, got);
        end
    endtask

    // one index per cycle on both ports and each result checked one cycle later
    task automatic read_back();
        int other;
        for (int i = 0; i <= `kLineSize; i++)
        begin
            @(posedge clk);
            waiting_done = 1'b0;
            if (i < `kLineSize)
            begin
                pr0_s <= nabp_pkg::s_index_t'(i);
                pr1_s <= nabp_pkg::s_index_t'((i + 23) % `kLineSize);
            end
            @(negedge clk);
            if (i > 0)
            begin
                other = (i - 1 + 23) % `kLineSize;
                check_value("pr0_val", i - 1, pr0_val, expected[i - 1]);
                check_value("pr1_val", other, pr1_val, expected[other]);
            end
        end
    endtask

    initial
    begin
        lfsr         = 32'd81744;
        errors       = 0;
        checks       = 0;
        waiting_done = 1'b0;
        reset_n      = 1'b0;
        raw_we       = 1'b0;
        raw_addr     = '0;
        raw_data     = '0;
        coef_we      = 1'b0;
        coef_idx     = '0;
        coef_data    = '0;
        fill_kick    = 1'b0;
        pr0_s        = '0;
        pr1_s        = '0;
        fill_table();
        repeat (2) @(posedge clk);
        reset_n <= 1'b1;
        // idle stretch while the monitor watches fill_done
        repeat (4) @(posedge clk);
        for (int r = 0; r < rows; r++)
        begin
            build_row(stim_table[r]);
            load_line();
            if (!stim_table[r].keep_taps)
                write_taps();
            run_fill(stim_table[r].second_kick);
            read_back();
        end
        @(posedge clk);
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* filtered_line_top.f */
+incdir+hdl
hdl/nabp_pkg.sv
hdl/line_dual_port_ram.sv
hdl/filter_coeff_regs.sv
hdl/projection_filter.sv
hdl/filtered_ram_fill.sv
hdl/filtered_line_top.sv
sim/filtered_line_tb.sv
